/* all.f */
hw/icache_pkg.sv
hw/instr_cache_set_multi.sv
hw/instr_cache_ctlr.sv
hw/icache_l1.sv
hw/icache_refill.sv
hw/icache_top.sv
test/tb_clock_gen.sv
test/tb_icache.sv

/* test/tb_icache.sv */
`timescale 1ns/1ns

module tb_icache;

    import icache_pkg::*;

    localparam int S         = 4;
    localparam int E         = 2;
    localparam int B         = 16;
    localparam int NumBeats  = B / 8;
    localparam int OffW      = $clog2(B);
    localparam int TagLsb    = OffW + $clog2(S);
    localparam int WaitLimit = 64;
    localparam int NumRandom = 200;
    localparam logic [31:0] WordKey = 32'h9e37_79b9;

    logic          clk;
    logic          reset;
    logic [31:0]   pc_f;
    pc_src_t       pc_src;
    logic [1:0]    branch_op;
    mem_rsp_t      mem_rsp;
    mem_req_t      mem_req;
    logic [31:0]   instr_f;
    fetch_status_t status;

    // Reference cache, recency kept as a use stamp
    logic          m_valid [S][E];
    logic [31:0]   m_tag   [S][E];
    int            m_stamp [S][E];
    int            stamp_ctr;

    // Memory model state
    logic          mem_busy;
    int            beat_idx;
    int            gap;
    logic [31:0]   blk_addr;
    logic [31:0]   beat_addr;
    logic [31:0]   gap_rng;
    int            req_count;
    logic [31:0]   last_req_addr;

    logic [31:0]   stim_rng;
    int            err_count;
    int            tests_run;
    logic          timed_out;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    icache_top #(
        .S (S),
        .E (E),
        .B (B)
    ) u_dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .pc_f_i        (pc_f),
        .pc_src_reg_i  (pc_src),
        .branch_op_e_i (branch_op),
        .mem_rsp_i     (mem_rsp),
        .mem_req_o     (mem_req),
        .instr_f_o     (instr_f),
        .status_o      (status)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Every memory word is its own address scrambled by a key
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ WordKey;
    endfunction

    function automatic int set_of(input logic [31:0] pc);
        return int'((pc >> OffW) % S);
    endfunction

    // Hit way in the model, -1 on a miss
    function automatic int model_way(input logic [31:0] pc);
        int s;
        int found;
        s = set_of(pc);
        found = -1;
        for (int w = 0; w < E; w++) begin
            if (m_valid[s][w] && (m_tag[s][w] == (pc >> TagLsb))) begin
                found = w;
            end
        end
        return found;
    endfunction

    task automatic model_touch(input int s, input int w);
        stamp_ctr++;
        m_stamp[s][w] = stamp_ctr;
    endtask

    task automatic model_fill(input logic [31:0] pc);
        int s;
        int victim;
        s = set_of(pc);
        victim = -1;
        // First invalid way, else least recently used
        for (int w = E - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                victim = w;
            end
        end
        if (victim < 0) begin
            victim = 0;
            for (int w = 1; w < E; w++) begin
                if (m_stamp[s][w] < m_stamp[s][victim]) begin
                    victim = w;
                end
            end
        end
        m_valid[s][victim] = 1'b1;
        m_tag[s][victim]   = pc >> TagLsb;
        model_touch(s, victim);
    endtask

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        err_count++;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("Test %s done with %0d errors", name, err_count - errs_before);
    endtask

    task automatic wait_rep_active(input logic level);
        int n;
        n = 0;
        while ((status.rep_active !== level) && (n < WaitLimit)) begin
            @(posedge clk);
            #3;
            n++;
        end
        if (status.rep_active !== level) begin
            report_error($sformatf("rep_active did not reach %0d within %0d cycles",
                                   level, WaitLimit));
            timed_out = 1'b1;
        end
    endtask

    // Drive 1 ns after the edge, look 2 ns later
    task automatic present(input logic [31:0] pc, input pc_src_t src);
        @(posedge clk);
        #1;
        pc_f      = pc;
        pc_src    = src;
        stim_rng  = next_rand(stim_rng);
        branch_op = stim_rng[1:0];
        #2;
    endtask

    task automatic fetch(input logic [31:0] pc, input pc_src_t src);
        int          way;
        int          reqs_before;
        logic [31:0] blk;
        way         = model_way(pc);
        blk         = pc & ~32'(B - 1);
        reqs_before = req_count;
        present(pc, src);
        if (status.instr_miss !== (way < 0)) begin
            mismatch("status_o.instr_miss", status.instr_miss, way < 0);
        end
        if (way >= 0) begin
            model_touch(set_of(pc), way);
            if (instr_f !== mem_word(pc)) begin
                mismatch("instr_f_o", instr_f, mem_word(pc));
            end
        end else if (src != PC_SRC_SEQ) begin
            // Fetch is flushed, nothing may start
            repeat (3) begin
                @(posedge clk);
                #3;
                if (status.rep_active !== 1'b0) begin
                    mismatch("status_o.rep_active", status.rep_active, 0);
                end
                if (mem_req.req !== 1'b0) begin
                    mismatch("mem_req_o.req", mem_req.req, 0);
                end
            end
        end else begin
            wait_rep_active(1'b1);
            if (!timed_out) begin
                wait_rep_active(1'b0);
            end
            if (!timed_out) begin
                if (req_count != reqs_before + 1) begin
                    report_error($sformatf("Expected one memory request for pc 0x%h, saw %0d",
                                           pc, req_count - reqs_before));
                end
                if (last_req_addr !== blk) begin
                    mismatch("mem_req_o.addr", last_req_addr, blk);
                end
                model_fill(pc);
                // Same pc now hits
                if (status.instr_miss !== 1'b0) begin
                    mismatch("status_o.instr_miss", status.instr_miss, 0);
                end
                if (instr_f !== mem_word(pc)) begin
                    mismatch("instr_f_o", instr_f, mem_word(pc));
                end
            end
        end
    endtask

    // Block read memory, random idle gap before every beat
    initial begin
        mem_rsp   = '0;
        mem_busy  = 1'b0;
        beat_idx  = 0;
        gap       = 0;
        blk_addr  = '0;
        req_count = 0;
        gap_rng   = next_rand(32'hde6f);
        forever begin
            @(posedge clk);
            #1;
            mem_rsp = '0;
            if (reset) begin
                mem_busy = 1'b0;
            end else begin
                if (!mem_busy && mem_req.req) begin
                    mem_busy      = 1'b1;
                    beat_idx      = 0;
                    blk_addr      = mem_req.addr;
                    last_req_addr = mem_req.addr;
                    req_count++;
                    gap_rng = next_rand(gap_rng);
                    gap     = int'(gap_rng % 4);
                end else if (mem_busy && !mem_req.req) begin
                    report_error("mem_req_o.req dropped before the last beat");
                    mem_busy = 1'b0;
                end
                if (mem_busy) begin
                    // Address held for the whole block
                    if (mem_req.addr !== blk_addr) begin
                        mismatch("mem_req_o.addr", mem_req.addr, blk_addr);
                    end
                    if (gap > 0) begin
                        gap--;
                    end else begin
                        beat_addr     = blk_addr + 32'(8 * beat_idx);
                        mem_rsp.valid = 1'b1;
                        mem_rsp.data  = {mem_word(beat_addr + 32'd4), mem_word(beat_addr)};
                        mem_rsp.last  = (beat_idx == NumBeats - 1);
                        beat_idx++;
                        if (mem_rsp.last) begin
                            mem_busy = 1'b0;
                        end else begin
                            gap_rng = next_rand(gap_rng);
                            gap     = int'(gap_rng % 4);
                        end
                    end
                end
            end
        end
    end

    initial begin
        #2_000_000;
        $display("Simulation time limit reached");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int          errs;
        int          n;
        logic [31:0] pc;
        pc_src_t     src;
        // Redirect held through reset so the idle pc starts no refill
        pc_f      = '0;
        pc_src    = PC_SRC_JAL;
        branch_op = '0;
        stim_rng  = 32'hde6f;
        stamp_ctr = 0;
        err_count = 0;
        tests_run = 0;
        timed_out = 1'b0;
        for (int s = 0; s < S; s++) begin
            for (int w = 0; w < E; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_stamp[s][w] = 0;
            end
        end
        n = 0;
        while ((reset !== 1'b0) && (n < 100)) begin
            @(posedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            report_error("Reset was never released");
            timed_out = 1'b1;
        end
        begin : tests
            if (timed_out) disable tests;
            errs = err_count;
            @(posedge clk);
            #3;
            if (status.rep_active !== 1'b0) begin
                mismatch("status_o.rep_active", status.rep_active, 0);
            end
            if (mem_req.req !== 1'b0) begin
                mismatch("mem_req_o.req", mem_req.req, 0);
            end
            fetch(32'h0000_1000, PC_SRC_JAL);
            end_test("reset", errs);

            errs = err_count;
            fetch(32'h0000_1008, PC_SRC_SEQ);
            if (timed_out) disable tests;
            end_test("cold_miss", errs);

            errs = err_count;
            for (int k = 0; k < B / 4; k++) begin
                fetch(32'h0000_1000 + 32'(4 * k), PC_SRC_SEQ);
            end
            end_test("line_hits", errs);

            // Three tags into set 2, one touched in between
            errs = err_count;
            fetch(32'h0001_0020, PC_SRC_SEQ);
            fetch(32'h0002_0024, PC_SRC_SEQ);
            fetch(32'h0001_0028, PC_SRC_SEQ);
            fetch(32'h0003_002c, PC_SRC_SEQ);
            fetch(32'h0003_0020, PC_SRC_SEQ);
            fetch(32'h0002_0020, PC_SRC_SEQ);
            fetch(32'h0001_0024, PC_SRC_SEQ);
            fetch(32'h0002_0028, PC_SRC_SEQ);
            if (timed_out) disable tests;
            end_test("lru", errs);

            errs = err_count;
            for (int i = 0; i < 6; i++) begin
                stim_rng = next_rand(stim_rng);
                fetch(32'h0100_0000 + 32'(i << 10) + (stim_rng & 32'h3c), PC_SRC_SEQ);
                if (timed_out) disable tests;
            end
            end_test("backpressure", errs);

            errs = err_count;
            fetch(32'h0200_0010, PC_SRC_BRANCH);
            fetch(32'h0200_0410, PC_SRC_JALR);
            fetch(32'h0200_0010, PC_SRC_SEQ);
            if (timed_out) disable tests;
            end_test("redirect", errs);

            // Small tag pool so hits, misses and evictions all show up
            errs = err_count;
            for (int i = 0; i < NumRandom; i++) begin
                stim_rng = next_rand(stim_rng);
                pc       = 32'h0004_0000 | (stim_rng & 32'h1fc);
                src      = (stim_rng[31:29] == 3'd0) ? pc_src_t'(stim_rng[28:27]) : PC_SRC_SEQ;
                fetch(pc, src);
                if (timed_out) disable tests;
            end
            end_test("random_mix", errs);
        end
        $display("Tests run: %0d, errors: %0d", tests_run, err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PeriodNs    = 8,
    parameter int ResetCycles = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // Release just after an edge, like any other input
    initial begin
        reset_o = 1'b1;
        repeat (ResetCycles) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ns

module icache_top #(
    parameter int S = 32,
    parameter int E = 4,
    parameter int B = 64
) (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // Fetch port
    input  logic [31:0]               pc_f_i,
    input  icache_pkg::pc_src_t       pc_src_reg_i,
    input  logic [1:0]                branch_op_e_i,

    // Memory port
    input  icache_pkg::mem_rsp_t      mem_rsp_i,
    output icache_pkg::mem_req_t      mem_req_o,

    output logic [31:0]               instr_f_o,
    output icache_pkg::fetch_status_t status_o
);

    import icache_pkg::*;

    // Refill beats into the array
    rep_beat_t rep_beat;

    icache_l1 #(
        .S (S),
        .E (E),
        .B (B)
    ) u_icache_l1 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .pc_f_i        (pc_f_i),
        .pc_src_reg_i  (pc_src_reg_i),
        .branch_op_e_i (branch_op_e_i),
        .rep_beat_i    (rep_beat),
        .instr_f_o     (instr_f_o),
        .status_o      (status_o)
    );

    icache_refill #(
        .B (B)
    ) u_icache_refill (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rep_active_i (status_o.rep_active),
        .pc_f_i       (pc_f_i),
        .mem_rsp_i    (mem_rsp_i),
        .mem_req_o    (mem_req_o),
        .rep_beat_o   (rep_beat)
    );

endmodule

/* hw/icache_refill.sv */
`timescale 1ns/1ns

module icache_refill #(
    parameter int B = 64
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Replacement in progress, from the cache controller
    input  logic                  rep_active_i,
    // Stalled fetch address of the missing line
    input  logic [31:0]           pc_f_i,

    input  icache_pkg::mem_rsp_t  mem_rsp_i,
    output icache_pkg::mem_req_t  mem_req_o,
    output icache_pkg::rep_beat_t rep_beat_o
);

    localparam int OffW = $clog2(B);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_DONE
    } refill_state_t;

    refill_state_t state_q;
    logic [31:0]   addr_q;

    // Request FSM
    // DONE holds until rep_active drops so each miss gives one block read
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RF_IDLE;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (rep_active_i) begin
                        state_q <= RF_REQ;
                    end
                end
                RF_REQ: begin
                    if (mem_rsp_i.valid && mem_rsp_i.last) begin
                        state_q <= RF_DONE;
                    end
                end
                RF_DONE: begin
                    if (!rep_active_i) begin
                        state_q <= RF_IDLE;
                    end
                end
                default: begin
                    state_q <= RF_IDLE;
                end
            endcase
        end
    end

    // Block aligned address captured as the request starts
    always_ff @(posedge clk_i) begin
        if ((state_q == RF_IDLE) && rep_active_i) begin
            addr_q <= {pc_f_i[31:OffW], {OffW{1'b0}}};
        end
    end

    assign mem_req_o.req  = (state_q == RF_REQ);
    assign mem_req_o.addr = addr_q;

    // Beats go straight through, same cycle
    assign rep_beat_o.ready = (state_q == RF_REQ) & mem_rsp_i.valid;
    assign rep_beat_o.word  = mem_rsp_i.data;

endmodule

/* hw/icache_l1.sv */
`timescale 1ns/1ns

module icache_l1 #(
    parameter int S = 32,
    parameter int E = 4,
    parameter int B = 64
) (
    input  logic                      clk_i,
    input  logic                      reset_i,

    // Fetch address and redirect info
    input  logic [31:0]               pc_f_i,
    input  icache_pkg::pc_src_t       pc_src_reg_i,
    input  logic [1:0]                branch_op_e_i,

    // Beats from the refill unit
    input  icache_pkg::rep_beat_t     rep_beat_i,

    output logic [31:0]               instr_f_o,
    output icache_pkg::fetch_status_t status_o
);

    // Address field widths
    localparam int OffW       = $clog2(B);
    localparam int SetW       = $clog2(S);
    localparam int NumTagBits = 32 - SetW - OffW;

    logic [OffW-1:0]       block;
    logic [SetW-1:0]       set;
    logic [NumTagBits-1:0] tag;

    logic [S-1:0]          active_array;
    logic [S-1:0]          miss_array;
    logic [31:0]           data_array [S];

    logic                  rep_active;
    logic                  instr_miss;
    logic                  rep_enable;

    // Split pc into offset, set and tag
    assign block = pc_f_i[OffW-1:0];
    assign set   = pc_f_i[SetW+OffW-1:OffW];
    assign tag   = pc_f_i[31:SetW+OffW];

    // Beats are written only while replacing
    assign rep_enable = rep_active & rep_beat_i.ready;

    for (genvar i = 0; i < S; i++) begin : g_set
        instr_cache_set_multi #(
            .B          (B),
            .NumTagBits (NumTagBits),
            .E          (E)
        ) u_instr_cache_set_multi (
            .clk_i        (clk_i),
            .reset_i      (reset_i),
            .active_set_i (active_array[i]),
            .rep_enable_i (rep_enable),
            .block_i      (block),
            .tag_i        (tag),
            .rep_word_i   (rep_beat_i.word),
            .data_o       (data_array[i]),
            .set_miss_o   (miss_array[i])
        );
    end

    instr_cache_ctlr #(
        .S (S)
    ) u_instr_cache_ctlr (
        .clk_i                    (clk_i),
        .reset_i                  (reset_i),
        .set_i                    (set),
        .miss_array_i             (miss_array),
        .pc_src_reg_i             (pc_src_reg_i),
        .branch_op_e_i            (branch_op_e_i),
        .active_array_o           (active_array),
        .instr_miss_f_o           (instr_miss),
        .instr_cache_rep_active_o (rep_active)
    );

    // Instruction from the addressed set
    assign instr_f_o = data_array[set];

    assign status_o.instr_miss = instr_miss;
    assign status_o.rep_active = rep_active;

endmodule

/* hw/instr_cache_ctlr.sv */
`timescale 1ns/1ns

module instr_cache_ctlr #(
    parameter int S = 32
) (
    input  logic                 clk_i,
    input  logic                 reset_i,

    // Set index from the fetch address
    input  logic [$clog2(S)-1:0] set_i,
    // Per-set miss flags
    input  logic [S-1:0]         miss_array_i,

    // Redirect information from execute
    input  icache_pkg::pc_src_t  pc_src_reg_i,
    input  logic [1:0]           branch_op_e_i,

    output logic [S-1:0]         active_array_o,
    output logic                 instr_miss_f_o,
    output logic                 instr_cache_rep_active_o
);

    import icache_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_REPLACE
    } ctlr_state_t;

    ctlr_state_t state_q;
    ctlr_state_t state_d;

    logic redirect;

    // One-hot set select
    always_comb begin
        active_array_o        = '0;
        active_array_o[set_i] = 1'b1;
    end

    // Miss only counts in the addressed set
    assign instr_miss_f_o = |(miss_array_i & active_array_o);

    // Fetch is being redirected
    // branch_op_e_i rides along with the pipeline and plays no part here
    assign redirect = (pc_src_reg_i != PC_SRC_SEQ);

    // Replacement FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // No refill for an instruction about to be flushed
                if (instr_miss_f_o && !redirect) begin
                    state_d = ST_REPLACE;
                end
            end
            ST_REPLACE: begin
                // Set stops missing once the fill has landed
                if (!instr_miss_f_o) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign instr_cache_rep_active_o = (state_q == ST_REPLACE);

endmodule

/* hw/instr_cache_set_multi.sv */
`timescale 1ns/1ns

module instr_cache_set_multi #(
    parameter int B          = 64,
    parameter int NumTagBits = 21,
    parameter int E          = 4
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Set select and replacement write enable
    input  logic                  active_set_i,
    input  logic                  rep_enable_i,

    // Address fields
    input  logic [$clog2(B)-1:0]  block_i,
    input  logic [NumTagBits-1:0] tag_i,

    // Refill beat
    input  logic [63:0]           rep_word_i,

    output logic [31:0]           data_o,
    output logic                  set_miss_o
);

    // Beats per line, one 64-bit beat holds two instructions
    localparam int NumBeats = B / 8;
    localparam int BeatW    = (NumBeats > 1) ? $clog2(NumBeats) : 1;
    localparam int WayW     = $clog2(E);

    // Per-way line state
    logic [NumTagBits-1:0] tag_q   [E];
    logic [E-1:0]          valid_q;
    logic [WayW-1:0]       age_q   [E];
    logic [63:0]           data_q  [E][NumBeats];

    // Fill bookkeeping
    logic [BeatW-1:0]      beat_cnt_q;
    logic [WayW-1:0]       victim_q;

    logic [E-1:0]          hit_vec;
    logic [WayW-1:0]       hit_way;
    logic [WayW-1:0]       victim_way;
    logic [WayW-1:0]       oldest_age;
    logic [WayW-1:0]       wr_way;
    logic [WayW-1:0]       touch_way;
    logic [BeatW-1:0]      rd_beat;
    logic [63:0]           rd_beat_word;
    logic                  wr_en;
    logic                  first_beat;
    logic                  last_beat;
    logic                  touch_en;

    // Tag compare across all valid ways
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < E; w++) begin
            if (valid_q[w] && (tag_q[w] == tag_i)) begin
                hit_vec[w] = 1'b1;
                hit_way    = WayW'(w);
            end
        end
    end

    assign set_miss_o = ~|hit_vec;

    // Word select, lower address sits in the low half of a beat
    assign rd_beat      = BeatW'(block_i >> 3);
    assign rd_beat_word = data_q[hit_way][rd_beat];
    assign data_o       = block_i[2] ? rd_beat_word[63:32] : rd_beat_word[31:0];

    // Victim choice
    // Oldest way first, lowest index wins a tie
    always_comb begin
        victim_way = '0;
        oldest_age = age_q[0];
        for (int w = 1; w < E; w++) begin
            if (age_q[w] > oldest_age) begin
                oldest_age = age_q[w];
                victim_way = WayW'(w);
            end
        end
        // Any invalid way overrides, lowest index
        for (int w = E - 1; w >= 0; w--) begin
            if (!valid_q[w]) begin
                victim_way = WayW'(w);
            end
        end
    end

    // Only the addressed set takes beats
    assign wr_en      = rep_enable_i & active_set_i;
    assign first_beat = (beat_cnt_q == '0);
    assign last_beat  = (beat_cnt_q == BeatW'(NumBeats - 1));

    // Victim is frozen after the first beat
    assign wr_way = first_beat ? victim_way : victim_q;

    // LRU touch on a hit in the active set or on fill completion
    assign touch_en  = (active_set_i & ~set_miss_o) | (wr_en & last_beat);
    assign touch_way = (wr_en & last_beat) ? wr_way : hit_way;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q    <= '0;
            beat_cnt_q <= '0;
            victim_q   <= '0;
            for (int w = 0; w < E; w++) begin
                age_q[w] <= '0;
            end
        end else begin
            if (wr_en) begin
                if (first_beat) begin
                    victim_q            <= victim_way;
                    // line is stale while it is being overwritten
                    valid_q[victim_way] <= 1'b0;
                end
                if (last_beat) begin
                    valid_q[wr_way] <= 1'b1;
                    beat_cnt_q      <= '0;
                end else begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                end
            end
            if (touch_en) begin
                // Touched way becomes newest, younger or equal ways age by one
                for (int w = 0; w < E; w++) begin
                    if (WayW'(w) == touch_way) begin
                        age_q[w] <= '0;
                    end else if (age_q[w] <= age_q[touch_way]) begin
                        age_q[w] <= age_q[w] + 1'b1;
                    end
                end
            end
        end
    end

    // Line data and tag
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            data_q[wr_way][beat_cnt_q] <= rep_word_i;
            // Tag lands with the final beat
            if (last_beat) begin
                tag_q[wr_way] <= tag_i;
            end
        end
    end

endmodule

/* hw/icache_pkg.sv */
package icache_pkg;

    // Fetch redirect source from execute
    // Anything other than SEQ means the fetched instruction is discarded
    typedef enum logic [1:0] {
        PC_SRC_SEQ    = 2'b00,
        PC_SRC_BRANCH = 2'b01,
        PC_SRC_JAL    = 2'b10,
        PC_SRC_JALR   = 2'b11
    } pc_src_t;

    // Block read request toward external memory
    typedef struct packed {
        logic        req;
        // Block aligned byte address
        logic [31:0] addr;
    } mem_req_t;

    // One 64-bit beat back from memory
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
        // Marks final beat of the block
        logic        last;
    } mem_rsp_t;

    // Replacement beat handed to the cache array
    typedef struct packed {
        logic        ready;
        logic [63:0] word;
    } rep_beat_t;

    // Fetch side status
    typedef struct packed {
        logic instr_miss;
        logic rep_active;
    } fetch_status_t;

endpackage
